//--- hdl/gram_accum.sv
`timescale 1ns/100ps

module gram_accum #(
    parameter int  MIC_NUM = 8,
    parameter int  LAMBDA  = 0,
    localparam int IDX_W   = $clog2(MIC_NUM)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pinv_pkg::ctrl_phase_t  phase,
    input  logic                   smp_valid,
    input  logic                   smp_src,
    input  logic [IDX_W-1:0]       smp_mic,
    input  pinv_pkg::cplx_sample_t smp_data,
    output pinv_pkg::gram_mat_t    gram
);
    import pinv_pkg::*;

    cplx_sample_t a0_copy [MIC_NUM];   // source 0, kept locally
    cplx_sample_t a0;
    logic         in_read_q;

    assign a0 = a0_copy[smp_mic];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_read_q <= 1'b0;
        end else begin
            in_read_q <= (phase == READ);
        end
    end

    // ==================================================
    // accumulation
    // ==================================================
    always_ff @(posedge clk) begin
        if (phase == READ && !in_read_q) begin
            gram <= '0;                                // first READ cycle
        end else if (phase == REGULARIZE) begin
            gram.g11 <= gram.g11 + gram_t'(LAMBDA);
            gram.g22 <= gram.g22 + gram_t'(LAMBDA);
        end else if (smp_valid && !smp_src) begin
            a0_copy[smp_mic] <= smp_data;
            gram.g11 <= gram.g11 + smp_data.re * smp_data.re + smp_data.im * smp_data.im;
        end else if (smp_valid) begin
            gram.g22 <= gram.g22 + smp_data.re * smp_data.re + smp_data.im * smp_data.im;
            // conj(a0) * a1
            gram.g12_re <= gram.g12_re + a0.re * smp_data.re + a0.im * smp_data.im;
            gram.g12_im <= gram.g12_im + a0.re * smp_data.im - a0.im * smp_data.re;
        end
    end

endmodule

//--- hdl/pinv_controller.sv
`timescale 1ns/100ps

module pinv_controller #(
    parameter int  MIC_NUM    = 8,
    parameter int  RD_LATENCY = 2,
    parameter int  FREQ_NUM   = 257,
    localparam int IDX_W      = $clog2(MIC_NUM)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        div_quot_valid,
    output logic                        rd_en,
    output logic [pinv_pkg::ADDR_W-1:0] rd_addr,
    output logic                        smp_valid,
    output logic                        smp_src,
    output logic [IDX_W-1:0]            smp_mic,
    output pinv_pkg::ctrl_phase_t       phase,
    input  logic                        wr_en,
    output logic [pinv_pkg::ADDR_W-1:0] wr_addr,
    output logic                        done,
    output logic                        all_freq_finish
);
    import pinv_pkg::*;

    localparam int CNT_W  = $clog2(2 * MIC_NUM + RD_LATENCY);
    localparam int FREQ_W = $clog2(FREQ_NUM + 1);

    logic [CNT_W-1:0]      cnt;        // shared by READ, DRAIN and WRITE
    logic [FREQ_W-1:0]     freq_cnt;
    logic [RD_LATENCY-1:0] vld_sr;
    logic                  last_wr;

    assign rd_en     = (phase == READ);
    assign done      = (phase == DONE);
    assign smp_valid = vld_sr[RD_LATENCY-1];
    assign last_wr   = (phase == WRITE) && wr_en && (cnt == CNT_W'(2 * MIC_NUM - 1));

    // ==================================================
    // phase sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= IDLE;
            cnt   <= '0;
        end else begin
            case (phase)
                IDLE:       if (start) phase <= READ;   // busy starts never get here
                READ: begin
                    if (cnt == CNT_W'(2 * MIC_NUM - 1)) begin
                        phase <= DRAIN;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (cnt == CNT_W'(RD_LATENCY - 1)) begin
                        phase <= REGULARIZE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                REGULARIZE: phase <= DET_MUL;
                DET_MUL:    phase <= DET_SUB;
                DET_SUB:    phase <= DIV_REQ;
                DIV_REQ:    phase <= DIV_WAIT;
                DIV_WAIT:   if (div_quot_valid) phase <= INVERT;
                INVERT:     phase <= WRITE;
                WRITE: begin
                    if (last_wr) begin
                        phase <= DONE;
                        cnt   <= '0;
                    end else if (wr_en) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default:    phase <= IDLE;      // DONE included
            endcase
        end
    end

    // frequency count and finish flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            freq_cnt        <= '0;
            all_freq_finish <= 1'b0;
        end else if (phase == IDLE && start) begin
            all_freq_finish <= 1'b0;
        end else if (last_wr) begin
            freq_cnt        <= (freq_cnt == FREQ_W'(FREQ_NUM - 1)) ? '0 : freq_cnt + 1'b1;
            all_freq_finish <= (freq_cnt == FREQ_W'(FREQ_NUM - 1));
        end
    end

    // ==================================================
    // read latency tracking and addresses
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr  <= '0;
            smp_src <= 1'b0;
            smp_mic <= '0;
            rd_addr <= '0;
            wr_addr <= '0;
        end else begin
            vld_sr <= (vld_sr << 1) | RD_LATENCY'(rd_en);
            if (smp_valid) begin
                if (smp_mic == IDX_W'(MIC_NUM - 1)) begin
                    smp_mic <= '0;
                    smp_src <= ~smp_src;   // wraps back to source 0 after 2*MIC_NUM
                end else begin
                    smp_mic <= smp_mic + 1'b1;
                end
            end
            if (rd_en)
                rd_addr <= rd_addr + 1'b1;
            if (wr_en)
                wr_addr <= wr_addr + 1'b1;
        end
    end

    // divider must not answer unless a request is pending
    a_quot_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        div_quot_valid |-> phase == DIV_WAIT);

endmodule

//--- hdl/pinv_pkg.sv
package pinv_pkg;

    localparam int SOURCES    = 2;
    localparam int ADDR_W     = 16;
    localparam int RECIP_FRAC = 30;   // reciprocal is 2^RECIP_FRAC / det

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // gram entries wrap modulo 2^32
    typedef logic signed [31:0] gram_t;

    typedef struct packed {
        gram_t g11;
        gram_t g22;
        gram_t g12_re;
        gram_t g12_im;
    } gram_mat_t;

    typedef logic signed [63:0] det_t;
    typedef logic signed [31:0] recip_t;
    typedef logic signed [63:0] inv_t;

    typedef struct packed {
        inv_t i11;
        inv_t i22;
        inv_t i12_re;
        inv_t i12_im;
    } inv_mat_t;

    typedef struct packed {
        logic signed [63:0] re;
        logic signed [63:0] im;
    } result_t;

    typedef enum logic [3:0] {
        IDLE,
        READ,
        DRAIN,
        REGULARIZE,
        DET_MUL,
        DET_SUB,
        DIV_REQ,
        DIV_WAIT,
        INVERT,
        WRITE,
        DONE
    } ctrl_phase_t;

endpackage

//--- hdl/pinv_solver.sv
`timescale 1ns/100ps

module pinv_solver #(
    parameter int  MIC_NUM = 8,
    localparam int IDX_W   = $clog2(MIC_NUM)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pinv_pkg::ctrl_phase_t  phase,
    input  pinv_pkg::gram_mat_t    gram,
    output logic                   div_req,
    output pinv_pkg::det_t         div_divisor,
    input  pinv_pkg::recip_t       div_quot,
    input  logic                   div_quot_valid,
    output logic [IDX_W-1:0]       vec_mic,
    input  pinv_pkg::cplx_sample_t vec_a0,
    input  pinv_pkg::cplx_sample_t vec_a1,
    output logic                   wr_en,
    output pinv_pkg::result_t      wr_data
);
    import pinv_pkg::*;

    det_t     det;
    recip_t   recip;
    inv_mat_t inv;
    result_t  c0;        // row coefficients
    result_t  c1;
    result_t  term0;
    result_t  term1;
    logic     row;
    logic     issue_done;

    // c * conj(a), low 64 bits
    function automatic result_t mul_conj(result_t c, cplx_sample_t a);
        result_t r;
        r.re = c.re * a.re + c.im * a.im;
        r.im = c.im * a.re - c.re * a.im;
        return r;
    endfunction

    assign div_req     = (phase == DIV_REQ);
    assign div_divisor = det;

    // ==================================================
    // determinant, reciprocal, inverse, products
    // ==================================================
    always_ff @(posedge clk) begin
        case (phase)
            DET_MUL:  det <= det_t'(gram.g11) * gram.g22;
            DET_SUB:  det <= det - (det_t'(gram.g12_re) * gram.g12_re
                                  + det_t'(gram.g12_im) * gram.g12_im);
            DIV_WAIT: if (div_quot_valid) recip <= div_quot;
            INVERT: begin
                inv.i11    <= inv_t'(gram.g22) * recip;
                inv.i22    <= inv_t'(gram.g11) * recip;
                inv.i12_re <= -(inv_t'(gram.g12_re) * recip);
                inv.i12_im <= -(inv_t'(gram.g12_im) * recip);
            end
            WRITE: begin
                term0 <= mul_conj(c0, vec_a0);
                term1 <= mul_conj(c1, vec_a1);
            end
            default: ;
        endcase
    end

    // row 1 uses invG21 = conj(invG12)
    always_comb begin
        if (!row) begin
            c0 = '{re: inv.i11, im: '0};
            c1 = '{re: inv.i12_re, im: inv.i12_im};
        end else begin
            c0 = '{re: inv.i12_re, im: -inv.i12_im};
            c1 = '{re: inv.i22, im: '0};
        end
    end

    // ==================================================
    // write sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row        <= 1'b0;
            vec_mic    <= '0;
            issue_done <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            wr_en <= (phase == WRITE) && !issue_done;   // terms valid next cycle
            if (phase == INVERT) begin
                row        <= 1'b0;
                vec_mic    <= '0;
                issue_done <= 1'b0;
            end else if (phase == WRITE && !issue_done) begin
                if (vec_mic == IDX_W'(MIC_NUM - 1)) begin
                    vec_mic    <= '0;
                    row        <= 1'b1;
                    issue_done <= row;
                end else begin
                    vec_mic <= vec_mic + 1'b1;
                end
            end
        end
    end

    assign wr_data = '{re: term0.re + term1.re, im: term0.im + term1.im};

endmodule

//--- hdl/pinv_top.sv
`timescale 1ns/100ps

module pinv_top #(
    parameter int MIC_NUM    = 8,
    parameter int RD_LATENCY = 2,
    parameter int FREQ_NUM   = 257,
    parameter int LAMBDA     = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output logic                        rd_en,
    output logic [pinv_pkg::ADDR_W-1:0] rd_addr,
    input  pinv_pkg::cplx_sample_t      rd_data,
    output logic                        div_req,
    output pinv_pkg::det_t              div_divisor,
    input  pinv_pkg::recip_t            div_quot,
    input  logic                        div_quot_valid,
    output logic                        wr_en,
    output logic [pinv_pkg::ADDR_W-1:0] wr_addr,
    output pinv_pkg::result_t           wr_data,
    output logic                        done,
    output logic                        all_freq_finish
);
    import pinv_pkg::*;

    localparam int IDX_W = $clog2(MIC_NUM);

    ctrl_phase_t      phase;
    gram_mat_t        gram;
    logic             smp_valid;
    logic             smp_src;
    logic [IDX_W-1:0] smp_mic;
    logic [IDX_W-1:0] vec_mic;
    cplx_sample_t     vec_a0;
    cplx_sample_t     vec_a1;

    pinv_controller #(
        .MIC_NUM        (MIC_NUM),
        .RD_LATENCY     (RD_LATENCY),
        .FREQ_NUM       (FREQ_NUM)
    ) pinv_controller_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .div_quot_valid (div_quot_valid),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .smp_valid      (smp_valid),
        .smp_src        (smp_src),
        .smp_mic        (smp_mic),
        .phase          (phase),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .done           (done),
        .all_freq_finish(all_freq_finish)
    );

    // read data fans out to both branches
    steering_buffer #(
        .MIC_NUM  (MIC_NUM)
    ) steering_buffer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .smp_valid(smp_valid),
        .smp_src  (smp_src),
        .smp_mic  (smp_mic),
        .smp_data (rd_data),
        .vec_mic  (vec_mic),
        .vec_a0   (vec_a0),
        .vec_a1   (vec_a1)
    );

    gram_accum #(
        .MIC_NUM  (MIC_NUM),
        .LAMBDA   (LAMBDA)
    ) gram_accum_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .smp_valid(smp_valid),
        .smp_src  (smp_src),
        .smp_mic  (smp_mic),
        .smp_data (rd_data),
        .gram     (gram)
    );

    pinv_solver #(
        .MIC_NUM       (MIC_NUM)
    ) pinv_solver_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .gram          (gram),
        .div_req       (div_req),
        .div_divisor   (div_divisor),
        .div_quot      (div_quot),
        .div_quot_valid(div_quot_valid),
        .vec_mic       (vec_mic),
        .vec_a0        (vec_a0),
        .vec_a1        (vec_a1),
        .wr_en         (wr_en),
        .wr_data       (wr_data)
    );

endmodule

//--- hdl/steering_buffer.sv
`timescale 1ns/100ps

module steering_buffer #(
    parameter int  MIC_NUM = 8,
    localparam int IDX_W   = $clog2(MIC_NUM)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   smp_valid,
    input  logic                   smp_src,
    input  logic [IDX_W-1:0]       smp_mic,
    input  pinv_pkg::cplx_sample_t smp_data,
    input  logic [IDX_W-1:0]       vec_mic,
    output pinv_pkg::cplx_sample_t vec_a0,
    output pinv_pkg::cplx_sample_t vec_a1
);
    import pinv_pkg::*;

    cplx_sample_t vec_mem [SOURCES][MIC_NUM];   // one row per source

    always_ff @(posedge clk) begin
        if (smp_valid)
            vec_mem[smp_src][smp_mic] <= smp_data;
    end

    // both sources at the same mic, read by the solver in WRITE
    assign vec_a0 = vec_mem[0][vec_mic];
    assign vec_a1 = vec_mem[1][vec_mic];

    a_mic_range: assert property (@(posedge clk) disable iff (!rst_n)
        smp_valid |-> smp_mic < MIC_NUM);

endmodule

//--- pinv_top.f
+incdir+test
hdl/pinv_pkg.sv
hdl/pinv_controller.sv
hdl/steering_buffer.sv
hdl/gram_accum.sv
hdl/pinv_solver.sv
hdl/pinv_top.sv
test/tb_pinv_top.sv

//--- run.sh
#!/bin/sh
# build and run the pinv testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pinv_top -f pinv_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pinv_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- test/tb_pinv_tasks.svh
`ifndef TB_PINV_TASKS_SVH
`define TB_PINV_TASKS_SVH

cplx_sample_t vec0 [MIC_NUM];   // source 0 steering vector
cplx_sample_t vec1 [MIC_NUM];
int           mem_base;

// ==================================================
// random bits and samples
// ==================================================
// x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

function automatic cplx_sample_t make_sample(int re, int im);
    cplx_sample_t s;
    s.re = sample_t'(re);
    s.im = sample_t'(im);
    return s;
endfunction

// small signed values keep det well away from wrap
function automatic sample_t rand_sample();
    logic [31:0] bits;
    bits = rand_bits(5);
    return sample_t'($signed(bits[4:0]));
endfunction

// ==================================================
// reference model
// ==================================================
function automatic recip_t recip_of(det_t d);
    if (d == 0)
        return '0;
    return recip_t'((64'sd1 <<< RECIP_FRAC) / d);   // truncates toward zero
endfunction

// c * conj(a)
function automatic result_t times_conj(longint c_re, longint c_im, cplx_sample_t a);
    result_t r;
    r.re = c_re * a.re + c_im * a.im;
    r.im = c_im * a.re - c_re * a.im;
    return r;
endfunction

task automatic model_freq();
    gram_t   g11;
    gram_t   g22;
    gram_t   g12_re;
    gram_t   g12_im;
    det_t    det;
    recip_t  recip;
    longint  i11;
    longint  i22;
    longint  i12_re;
    longint  i12_im;
    result_t t0;
    result_t t1;
    result_t r;
    g11    = '0;
    g22    = '0;
    g12_re = '0;
    g12_im = '0;
    for (int m = 0; m < MIC_NUM; m++) begin
        g11    = g11 + vec0[m].re * vec0[m].re + vec0[m].im * vec0[m].im;
        g22    = g22 + vec1[m].re * vec1[m].re + vec1[m].im * vec1[m].im;
        g12_re = g12_re + vec0[m].re * vec1[m].re + vec0[m].im * vec1[m].im;
        g12_im = g12_im + vec0[m].re * vec1[m].im - vec0[m].im * vec1[m].re;
    end
    g11 = g11 + gram_t'(LAMBDA);
    g22 = g22 + gram_t'(LAMBDA);
    det = det_t'(g11) * g22 - det_t'(g12_re) * g12_re - det_t'(g12_im) * g12_im;
    det_q.push_back(det);
    recip  = recip_of(det);
    i11    = longint'(g22) * recip;
    i22    = longint'(g11) * recip;
    i12_re = -(longint'(g12_re) * recip);
    i12_im = -(longint'(g12_im) * recip);
    for (int k = 0; k < 2; k++) begin
        for (int m = 0; m < MIC_NUM; m++) begin
            if (k == 0) begin
                t0 = times_conj(i11, 0, vec0[m]);
                t1 = times_conj(i12_re, i12_im, vec1[m]);
            end else begin
                t0 = times_conj(i12_re, -i12_im, vec0[m]);   // invG21
                t1 = times_conj(i22, 0, vec1[m]);
            end
            r.re = t0.re + t1.re;
            r.im = t0.im + t1.im;
            res_q.push_back(r);
        end
    end
endtask

// ==================================================
// compare and report
// ==================================================
task automatic report_failure(string msg);
    err_cnt++;
    $display("%0t ns: %s", $time, msg);
endtask

task automatic check_result(string name, result_t got, result_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Error: %s got re %h im %h, expected re %h im %h",
                 name, got.re, got.im, exp.re, exp.im);
    end
endtask

task automatic check_det(string name, det_t got, det_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Error: %s got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_addr(string name, logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Error: %s got %h, expected %h", name, got, exp);
    end
endtask

task automatic expect_count(string what, int got, int exp);
    check_cnt++;
    if (got != exp)
        report_failure($sformatf("saw %0d %s where %0d were expected", got, what, exp));
endtask

// ==================================================
// sequencing helpers
// ==================================================
task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    start = 1'b0;
    det_q.delete();
    res_q.delete();
    exp_rd_addr = '0;
    exp_wr_addr = '0;
    rd_cnt      = 0;
    wr_cnt      = 0;
    done_cnt    = 0;
    req_cnt     = 0;
    mem_base    = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
endtask

task automatic random_vectors();
    for (int m = 0; m < MIC_NUM; m++) begin
        vec0[m].re = rand_sample();
        vec0[m].im = rand_sample();
        vec1[m].re = rand_sample();
        vec1[m].im = rand_sample();
    end
endtask

// one frequency, optionally poking start while busy
task automatic run_freq(int delay, bit poke_busy);
    int cyc;
    bit seen;
    cyc  = 0;
    seen = 1'b0;
    for (int m = 0; m < MIC_NUM; m++) begin
        mem[mem_base + m]           = vec0[m];
        mem[mem_base + MIC_NUM + m] = vec1[m];
    end
    mem_base  = mem_base + 2 * MIC_NUM;
    div_delay = delay;
    model_freq();
    @(negedge clk);
    start = 1'b1;
    while (!seen && cyc < DONE_TIMEOUT) begin
        @(negedge clk);
        cyc++;
        seen  = done;
        start = poke_busy && !seen && (cyc % 6 == 3);
    end
    start = 1'b0;
    if (!seen)
        report_failure($sformatf("no done pulse within %0d cycles of start", DONE_TIMEOUT));
    repeat (2) @(negedge clk);
    if (res_q.size() != 0)
        report_failure($sformatf("%0d expected results were never written", res_q.size()));
endtask

// ==================================================
// directed tests
// ==================================================
task automatic test_idle_after_reset();
    apply_reset();
    repeat (20) begin
        @(negedge clk);
        if (rd_en || wr_en || div_req || done || all_freq_finish)
            report_failure("outputs active after reset with no start");
    end
endtask

task automatic test_hand_vectors();
    apply_reset();
    vec0[0] = make_sample(3, 1);
    vec0[1] = make_sample(-2, 4);
    vec0[2] = make_sample(5, 0);
    vec0[3] = make_sample(1, -3);
    vec1[0] = make_sample(1, 2);
    vec1[1] = make_sample(0, -1);
    vec1[2] = make_sample(-4, 3);
    vec1[3] = make_sample(2, 2);
    run_freq(5, 1'b0);
    expect_count("results", wr_cnt, 2 * MIC_NUM);
    expect_count("done pulses", done_cnt, 1);
    if (all_freq_finish !== 1'b0)
        report_failure("all_freq_finish set after the first frequency");
endtask

task automatic test_random_freqs();
    int delay;
    apply_reset();
    for (int f = 0; f < FREQ_NUM; f++) begin
        random_vectors();
        delay = 1 + int'(rand_bits(5) % MAX_DIV_DELAY);
        run_freq(delay, 1'b0);
        expect_count("done pulses", done_cnt, f + 1);
        if (all_freq_finish !== (f == FREQ_NUM - 1))
            report_failure($sformatf("all_freq_finish is %b after frequency %0d",
                                     all_freq_finish, f));
    end
    // both address counters carried across frequencies
    check_addr("rd_addr", rd_addr, ADDR_W'(2 * MIC_NUM * FREQ_NUM));
    check_addr("wr_addr", wr_addr, ADDR_W'(2 * MIC_NUM * FREQ_NUM));
    expect_count("reads", rd_cnt, 2 * MIC_NUM * FREQ_NUM);
    expect_count("results", wr_cnt, 2 * MIC_NUM * FREQ_NUM);
endtask

task automatic test_busy_start();
    apply_reset();
    random_vectors();
    run_freq(12, 1'b1);
    repeat (10) @(negedge clk);
    expect_count("reads", rd_cnt, 2 * MIC_NUM);
    expect_count("results", wr_cnt, 2 * MIC_NUM);
    expect_count("done pulses", done_cnt, 1);
    expect_count("divider requests", req_cnt, 1);
endtask

`endif

//--- test/tb_pinv_top.sv
`timescale 1ns/100ps

module tb_pinv_top;
    import pinv_pkg::*;

    localparam int MIC_NUM       = 4;
    localparam int RD_LATENCY    = 2;
    localparam int FREQ_NUM      = 3;
    localparam int LAMBDA        = 16;
    localparam int CLK_PERIOD    = 4;
    localparam int MAX_DIV_DELAY = 20;
    localparam int DONE_TIMEOUT  = 30 + MAX_DIV_DELAY + 20;   // cycles from start to done
    localparam int RUN_FREQS     = 5;                         // hand, three random, busy
    localparam int WATCHDOG_NS   = RUN_FREQS * (30 + MAX_DIV_DELAY) * CLK_PERIOD
                                   + 200 * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    cplx_sample_t      rd_data        = '0;
    logic              div_req;
    det_t              div_divisor;
    recip_t            div_quot       = '0;
    logic              div_quot_valid = 1'b0;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    result_t           wr_data;
    logic              done;
    logic              all_freq_finish;

    // memory model
    cplx_sample_t mem [256];
    cplx_sample_t rd_pipe [RD_LATENCY];

    // divider model
    int     div_delay    = 1;
    int     div_wait_cnt = 0;
    logic   div_busy     = 1'b0;
    recip_t quot_hold    = '0;

    // scoreboard
    det_t              det_q [$];
    result_t           res_q [$];
    logic [ADDR_W-1:0] exp_rd_addr;
    logic [ADDR_W-1:0] exp_wr_addr;
    int                rd_cnt;
    int                wr_cnt;
    int                done_cnt;
    int                req_cnt;
    int                check_cnt;
    int                err_cnt;
    logic [31:0]       lfsr_state;

    `include "tb_pinv_tasks.svh"

    pinv_top #(
        .MIC_NUM        (MIC_NUM),
        .RD_LATENCY     (RD_LATENCY),
        .FREQ_NUM       (FREQ_NUM),
        .LAMBDA         (LAMBDA)
    ) pinv_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .div_req        (div_req),
        .div_divisor    (div_divisor),
        .div_quot       (div_quot),
        .div_quot_valid (div_quot_valid),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .done           (done),
        .all_freq_finish(all_freq_finish)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // memory and divider models
    // ==================================================
    always @(negedge clk) begin
        rd_pipe[0] <= rd_en ? mem[rd_addr[7:0]] : '0;
        for (int i = 1; i < RD_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i - 1];
        rd_data <= rd_pipe[RD_LATENCY - 1];   // lands RD_LATENCY cycles after rd_en
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            div_busy       <= 1'b0;
            div_wait_cnt   <= 0;
            div_quot_valid <= 1'b0;
        end else begin
            div_quot_valid <= 1'b0;
            if (div_req) begin
                div_busy     <= 1'b1;
                div_wait_cnt <= 1;
                quot_hold    <= recip_of(div_divisor);
            end else if (div_busy) begin
                if (div_wait_cnt >= div_delay) begin
                    div_quot       <= quot_hold;
                    div_quot_valid <= 1'b1;
                    div_busy       <= 1'b0;
                end else begin
                    div_wait_cnt <= div_wait_cnt + 1;
                end
            end
        end
    end

    // output monitor, mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_en) begin
                check_addr("rd_addr", rd_addr, exp_rd_addr);
                exp_rd_addr = exp_rd_addr + 1'b1;
                rd_cnt++;
            end
            if (div_req) begin
                req_cnt++;
                if (det_q.size() == 0)
                    report_failure("divider request with no frequency pending");
                else
                    check_det("div_divisor", div_divisor, det_q.pop_front());
            end
            if (wr_en) begin
                check_addr("wr_addr", wr_addr, exp_wr_addr);
                exp_wr_addr = exp_wr_addr + 1'b1;
                wr_cnt++;
                if (res_q.size() == 0)
                    report_failure("result written with none expected");
                else
                    check_result("wr_data", wr_data, res_q.pop_front());
            end
            if (done)
                done_cnt++;
        end
    end

    initial begin
        start      = 1'b0;
        rst_n      = 1'b0;
        lfsr_state = 32'd32057;
        check_cnt  = 0;
        err_cnt    = 0;
        test_idle_after_reset();
        test_hand_vectors();
        test_random_freqs();
        test_busy_start();
        $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule
